/* verilog/mfpu_pkg.sv */
// Shared widths, encodings and packed structs of the integer SIMD
// multiply-and-merge lane unit
`default_nettype none

package mfpu_pkg;

  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;
  localparam int unsigned NrVInsn   = 8;

  typedef logic [ElenWidth-1:0]       elen_t;
  typedef logic [StrbWidth-1:0]       strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [8:0]                 vlen_t;
  typedef logic [7:0]                 vaddr_t;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMACC  = 2'd1,
    VMERGE = 2'd2
  } mfpu_op_e;

  typedef struct packed {
    vid_t       id;
    mfpu_op_e   op;
    vew_e       vew;
    vlen_t      vl;
    logic [4:0] vd;
    logic       vm;          // Unmasked instruction
    logic       use_scalar;
    elen_t      scalar_op;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd;
  } mfpu_insn_t;

  // One word operation in flight; the pipeline returns its result in a
  typedef struct packed {
    mfpu_op_e op;
    vew_e     vew;
    elen_t    a;
    elen_t    b;
    elen_t    c;
    strb_t    mask;
  } mfpu_beat_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } mfpu_result_t;

  function automatic vlen_t elems_per_word(vew_e vew);
    return vlen_t'(StrbWidth) >> vew;
  endfunction

  // Byte enables covering the first cnt elements of a word
  function automatic strb_t elem_be(vlen_t cnt, vew_e vew);
    logic [11:0] nbytes;
    strb_t       be;
    nbytes = {3'b000, cnt} << vew;
    for (int b = 0; b < StrbWidth; b++) begin
      be[b] = (nbytes > b);
    end
    return be;
  endfunction

endpackage

`default_nettype wire

/* verilog/mfpu_result_queue.sv */
// Small circular FIFO with a valid/ready handshake on both sides
`timescale 1ns/1ps
`default_nettype none

module mfpu_result_queue #(
  parameter int unsigned Depth     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]   cnt_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (cnt_q != CntWidth'(Depth));
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntWidth'(push) - CntWidth'(pop);
    end
  end

endmodule

`default_nettype wire

/* verilog/mfpu_insn_queue.sv */
// Instruction queue of the multiply-and-merge unit. Tracks every held
// instruction through issue, processing and commit, and reports completion.
`timescale 1ns/1ps
`default_nettype none

module mfpu_insn_queue #(
  parameter int unsigned Depth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  mfpu_pkg::mfpu_insn_t           insn_i,
  input  logic                           insn_valid_i,
  output logic                           insn_ready_o,
  output mfpu_pkg::mfpu_insn_t           issue_insn_o,
  output logic                           issue_valid_o,
  input  logic                           issue_done_i,
  output mfpu_pkg::mfpu_insn_t           proc_insn_o,
  output logic                           proc_valid_o,
  input  logic                           proc_done_i,
  input  logic                           commit_gnt_i,
  output logic [mfpu_pkg::NrVInsn-1:0]   done_o
);
  import mfpu_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  mfpu_insn_t insn_q [Depth];
  ptr_t       accept_ptr_q, issue_ptr_q, proc_ptr_q, commit_ptr_q;
  cnt_t       issue_cnt_q, proc_cnt_q, commit_cnt_q;
  mfpu_insn_t commit_insn;
  vlen_t      commit_epw;
  vlen_t      commit_left;
  vlen_t      commit_left_q;
  logic       commit_fresh_q;
  logic       accept;
  logic       commit_done;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Every held instruction stays counted until its last word is committed
  assign insn_ready_o = (commit_cnt_q != cnt_t'(Depth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o  = insn_q[issue_ptr_q];
  assign issue_valid_o = (issue_cnt_q != '0);
  assign proc_insn_o   = insn_q[proc_ptr_q];
  assign proc_valid_o  = (proc_cnt_q != '0);

  // Commit head counts down granted elements, reloaded from vl when it changes
  assign commit_insn = insn_q[commit_ptr_q];
  assign commit_epw  = elems_per_word(commit_insn.vew);
  assign commit_left = commit_fresh_q ? commit_insn.vl : commit_left_q;
  assign commit_done = commit_gnt_i && (commit_left <= commit_epw);

  always_comb begin
    done_o = '0;
    if (commit_done) begin
      done_o[commit_insn.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_ptr_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q   <= '0;
      issue_ptr_q    <= '0;
      proc_ptr_q     <= '0;
      commit_ptr_q   <= '0;
      issue_cnt_q    <= '0;
      proc_cnt_q     <= '0;
      commit_cnt_q   <= '0;
      commit_left_q  <= '0;
      commit_fresh_q <= 1'b1;
    end else begin
      if (accept) accept_ptr_q <= next_ptr(accept_ptr_q);
      if (issue_done_i) issue_ptr_q <= next_ptr(issue_ptr_q);
      if (proc_done_i) proc_ptr_q <= next_ptr(proc_ptr_q);
      if (commit_done) commit_ptr_q <= next_ptr(commit_ptr_q);
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(proc_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done);
      if (commit_gnt_i) begin
        commit_left_q  <= commit_done ? '0 : commit_left - commit_epw;
        commit_fresh_q <= commit_done;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mfpu_issue.sv */
// Issue stage. Collects the operand words and mask of the issue head,
// replicates the scalar and hands one beat per word to the pipeline.
`timescale 1ns/1ps
`default_nettype none

module mfpu_issue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mfpu_pkg::mfpu_insn_t  insn_i,
  input  logic                  insn_valid_i,
  input  mfpu_pkg::elen_t [2:0] operand_i,
  input  logic [2:0]            operand_valid_i,
  output logic [2:0]            operand_ready_o,
  input  mfpu_pkg::strb_t       mask_i,
  input  logic                  mask_valid_i,
  output logic                  mask_ready_o,
  output mfpu_pkg::mfpu_beat_t  beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  output logic                  insn_done_o
);
  import mfpu_pkg::*;

  logic [2:0] used;
  logic       operands_valid;
  logic       fire;
  vlen_t      epw;
  vlen_t      remaining;
  vlen_t      issue_n;
  vlen_t      cnt_q;
  logic       fresh_q;
  elen_t      scalar;

  // Queues 0, 1 and 2 carry vs1, vs2 and vd
  assign used           = {insn_i.use_vd, insn_i.use_vs2, insn_i.use_vs1};
  assign operands_valid = &(operand_valid_i | ~used) && (mask_valid_i || insn_i.vm);
  assign beat_valid_o   = insn_valid_i && operands_valid;
  assign fire           = beat_valid_o && beat_ready_i;

  assign operand_ready_o = fire ? used : 3'b000;
  assign mask_ready_o    = fire && !insn_i.vm;

  // Elements left to issue, taken from vl on the first beat of a head
  assign epw         = elems_per_word(insn_i.vew);
  assign remaining   = fresh_q ? insn_i.vl : cnt_q;
  assign issue_n     = (remaining < epw) ? remaining : epw;
  assign insn_done_o = fire && (remaining <= epw);

  always_comb begin
    case (insn_i.vew)
      EW8:     scalar = {8{insn_i.scalar_op[7:0]}};
      EW16:    scalar = {4{insn_i.scalar_op[15:0]}};
      EW32:    scalar = {2{insn_i.scalar_op[31:0]}};
      default: scalar = insn_i.scalar_op;
    endcase
  end

  always_comb begin
    beat_o.op  = insn_i.op;
    beat_o.vew = insn_i.vew;
    beat_o.a   = insn_i.use_scalar ? scalar : operand_i[0];
    beat_o.b   = operand_i[1];
    beat_o.c   = operand_i[2];
    // Unmasked instructions see all mask bits set, tail elements none
    beat_o.mask = (insn_i.vm ? {StrbWidth{1'b1}} : mask_i) & elem_be(issue_n, insn_i.vew);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      fresh_q <= 1'b1;
    end else if (fire) begin
      cnt_q   <= remaining - issue_n;
      fresh_q <= insn_done_o;
    end
  end

endmodule

`default_nettype wire

/* verilog/mfpu_simd_mul.sv */
// SIMD multiply, multiply-accumulate and merge pipeline for all element
// widths. The mask travels with each beat.
`timescale 1ns/1ps
`default_nettype none

module mfpu_simd_mul #(
  parameter int unsigned NumStages = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  mfpu_pkg::mfpu_beat_t beat_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output mfpu_pkg::mfpu_beat_t beat_o,
  output logic                 valid_o,
  input  logic                 ready_i
);
  import mfpu_pkg::*;

  mfpu_beat_t                 head;
  mfpu_beat_t [NumStages-1:0] stage_q;
  logic       [NumStages-1:0] valid_q;
  elen_t                      addend;
  logic                       merge;
  logic                       advance;

  assign addend = (beat_i.op == VMACC) ? beat_i.c : '0;
  assign merge  = (beat_i.op == VMERGE);

  // Low element bits only, so each product is sized to its element
  always_comb begin
    head = beat_i;
    case (beat_i.vew)
      EW8:
        for (int e = 0; e < 8; e++) begin
          head.a[8*e +: 8] = merge
            ? (beat_i.mask[e] ? beat_i.a[8*e +: 8] : beat_i.b[8*e +: 8])
            : beat_i.a[8*e +: 8] * beat_i.b[8*e +: 8] + addend[8*e +: 8];
        end
      EW16:
        for (int e = 0; e < 4; e++) begin
          head.a[16*e +: 16] = merge
            ? (beat_i.mask[2*e] ? beat_i.a[16*e +: 16] : beat_i.b[16*e +: 16])
            : beat_i.a[16*e +: 16] * beat_i.b[16*e +: 16] + addend[16*e +: 16];
        end
      EW32:
        for (int e = 0; e < 2; e++) begin
          head.a[32*e +: 32] = merge
            ? (beat_i.mask[4*e] ? beat_i.a[32*e +: 32] : beat_i.b[32*e +: 32])
            : beat_i.a[32*e +: 32] * beat_i.b[32*e +: 32] + addend[32*e +: 32];
        end
      default:
        head.a = merge
          ? (beat_i.mask[0] ? beat_i.a : beat_i.b)
          : beat_i.a * beat_i.b + addend;
    endcase
  end

  // All stages move together when the output slot is free or taken
  assign advance = !valid_q[NumStages-1] || ready_i;
  assign ready_o = advance;
  assign valid_o = valid_q[NumStages-1];
  assign beat_o  = stage_q[NumStages-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < NumStages; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_q[0] <= head;
      for (int s = 1; s < NumStages; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mfpu_writeback.sv */
// Processing stage. Turns each pipeline result into a register-file write
// with address and byte enables for the processing head.
`timescale 1ns/1ps
`default_nettype none

module mfpu_writeback #(
  parameter int unsigned VRegWords = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mfpu_pkg::mfpu_insn_t   insn_i,
  input  logic                   insn_valid_i,
  input  mfpu_pkg::mfpu_beat_t   beat_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  output mfpu_pkg::mfpu_result_t result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i,
  output logic                   insn_done_o
);
  import mfpu_pkg::*;

  vlen_t epw;
  vlen_t remaining;
  vlen_t proc_n;
  vlen_t word_idx;
  vlen_t cnt_q;
  logic  fresh_q;
  logic  fire;
  strb_t keep;

  assign result_valid_o = valid_i && insn_valid_i;
  assign ready_o        = result_ready_i && insn_valid_i;
  assign fire           = result_valid_o && result_ready_i;

  assign epw         = elems_per_word(insn_i.vew);
  assign remaining   = fresh_q ? insn_i.vl : cnt_q;
  assign proc_n      = (remaining < epw) ? remaining : epw;
  assign insn_done_o = fire && (remaining <= epw);

  // Words already written, as element count divided by elements per word
  assign word_idx = (insn_i.vl - remaining) >> (2'd3 - insn_i.vew);

  // Each byte takes the mask bit of the first byte of its element.
  // Merge writes every active element whatever its mask bit
  always_comb begin
    for (int b = 0; b < StrbWidth; b++) begin
      case (insn_i.vew)
        EW8:     keep[b] = beat_i.mask[b];
        EW16:    keep[b] = beat_i.mask[b & ~1];
        EW32:    keep[b] = beat_i.mask[b & ~3];
        default: keep[b] = beat_i.mask[0];
      endcase
      if (insn_i.vm || insn_i.op == VMERGE) begin
        keep[b] = 1'b1;
      end
    end
  end

  always_comb begin
    result_o.id    = insn_i.id;
    result_o.addr  = vaddr_t'(insn_i.vd) * vaddr_t'(VRegWords) + vaddr_t'(word_idx);
    result_o.wdata = beat_i.a;
    result_o.be    = elem_be(proc_n, insn_i.vew) & keep;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      fresh_q <= 1'b1;
    end else if (fire) begin
      cnt_q   <= remaining - proc_n;
      fresh_q <= insn_done_o;
    end
  end

endmodule

`default_nettype wire

/* verilog/vmfpu.sv */
// Integer SIMD multiply-and-merge unit for one vector lane. Connects the
// instruction queue, issue stage, pipeline, writeback and result queue.
`timescale 1ns/1ps
`default_nettype none

module vmfpu #(
  parameter int unsigned VRegWords  = 8,
  parameter int unsigned MulLatency = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  mfpu_pkg::mfpu_insn_t         insn_i,
  input  logic                         insn_valid_i,
  output logic                         insn_ready_o,
  input  mfpu_pkg::elen_t [2:0]        operand_i,
  input  logic [2:0]                   operand_valid_i,
  output logic [2:0]                   operand_ready_o,
  input  mfpu_pkg::strb_t              mask_i,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  output mfpu_pkg::mfpu_result_t       result_o,
  output logic                         result_req_o,
  input  logic                         result_gnt_i,
  output logic [mfpu_pkg::NrVInsn-1:0] done_o
);
  import mfpu_pkg::*;

  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;

  mfpu_insn_t   issue_insn, proc_insn;
  logic         issue_valid, proc_valid;
  logic         issue_done, proc_done;
  mfpu_beat_t   issue_beat, mul_beat;
  logic         issue_beat_valid, issue_beat_ready;
  logic         mul_valid, mul_ready;
  mfpu_result_t wb_result;
  logic         wb_valid, wb_ready;
  logic         commit_gnt;

  assign commit_gnt = result_req_o && result_gnt_i;

  mfpu_insn_queue #(
    .Depth (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .proc_insn_o   (proc_insn),
    .proc_valid_o  (proc_valid),
    .proc_done_i   (proc_done),
    .commit_gnt_i  (commit_gnt),
    .done_o        (done_o)
  );

  mfpu_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .beat_o          (issue_beat),
    .beat_valid_o    (issue_beat_valid),
    .beat_ready_i    (issue_beat_ready),
    .insn_done_o     (issue_done)
  );

  mfpu_simd_mul #(
    .NumStages (MulLatency)
  ) i_simd_mul (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .beat_i  (issue_beat),
    .valid_i (issue_beat_valid),
    .ready_o (issue_beat_ready),
    .beat_o  (mul_beat),
    .valid_o (mul_valid),
    .ready_i (mul_ready)
  );

  mfpu_writeback #(
    .VRegWords (VRegWords)
  ) i_writeback (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (proc_insn),
    .insn_valid_i   (proc_valid),
    .beat_i         (mul_beat),
    .valid_i        (mul_valid),
    .ready_o        (mul_ready),
    .result_o       (wb_result),
    .result_valid_o (wb_valid),
    .result_ready_i (wb_ready),
    .insn_done_o    (proc_done)
  );

  mfpu_result_queue #(
    .Depth     (ResultQueueDepth),
    .payload_t (mfpu_result_t)
  ) i_result_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (wb_result),
    .valid_i (wb_valid),
    .ready_o (wb_ready),
    .data_o  (result_o),
    .valid_o (result_req_o),
    .ready_i (result_gnt_i)
  );

endmodule

`default_nettype wire

/* verif/vmfpu_properties.sv */
// Handshake and completion properties of the multiply-and-merge unit
`timescale 1ns/1ps
`default_nettype none

module vmfpu_properties (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         insn_valid_i,
  input logic                         insn_ready_o,
  input logic [2:0]                   operand_ready_o,
  input logic                         mask_ready_o,
  input mfpu_pkg::mfpu_result_t       result_o,
  input logic                         result_req_o,
  input logic                         result_gnt_i,
  input logic [mfpu_pkg::NrVInsn-1:0] done_o
);

  logic seen_insn_q;

  // Set once the first instruction has been taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_insn_q <= 1'b0;
    end else if (insn_valid_i && insn_ready_o) begin
      seen_insn_q <= 1'b1;
    end
  end

  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else $error("result request withdrawn or changed before its grant");

  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_o))
    else $error("more than one done bit set in the same cycle");

  // An empty unit accepts instructions and pulls no operands
  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_insn_q |-> insn_ready_o && operand_ready_o == '0 && !mask_ready_o)
    else $error("operand or mask ready raised while the unit is empty");

endmodule

`default_nettype wire

/* verif/tb_vmfpu.sv */
// Testbench for the integer SIMD multiply-and-merge lane unit. Streams
// operands, checks every granted result against a reference model.
`timescale 1ns/1ps
`default_nettype none

module tb_vmfpu;
  import mfpu_pkg::*;

  localparam int unsigned VRegWords  = 8;
  localparam int unsigned MulLatency = 2;
  localparam int          ClkPeriod  = 100;
  localparam int          NumTests   = 5;

  // One operand beat: expected readies, vs1, vs2 and vd words plus the mask byte
  typedef struct packed {
    logic [2:0]  used;
    logic        need_mask;
    strb_t       mask;
    elen_t [2:0] ops;
  } src_t;

  logic               clk_i;
  logic               rst_ni;
  mfpu_insn_t         insn_i;
  logic               insn_valid_i;
  logic               insn_ready_o;
  elen_t [2:0]        operand_i;
  logic [2:0]         operand_valid_i;
  logic [2:0]         operand_ready_o;
  strb_t              mask_i;
  logic               mask_valid_i;
  logic               mask_ready_o;
  mfpu_result_t       result_o;
  logic               result_req_o;
  logic               result_gnt_i;
  logic [NrVInsn-1:0] done_o;

  src_t         src_q[$];
  mfpu_result_t exp_q[$];
  bit           last_q[$];
  integer       seed = 32'he2a8_bb4c;
  string        cur_test = "reset";
  int           errors;
  int           err_start;
  int           tests_run;
  int           tests_failed;
  int           held;
  bit           stall_en;
  bit           saw_full;
  vid_t         next_id;

  vmfpu #(
    .VRegWords  (VRegWords),
    .MulLatency (MulLatency)
  ) i_vmfpu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  bind vmfpu vmfpu_properties i_properties (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_ready_o (operand_ready_o),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Reference result word, computed element by element
  function automatic elen_t model_word(mfpu_insn_t insn, elen_t vs1, elen_t vs2, elen_t vd,
                                       strb_t mask);
    int unsigned w;
    int unsigned sh;
    elen_t       emask;
    elen_t       a;
    elen_t       b;
    elen_t       c;
    elen_t       r;
    elen_t       res;
    w     = 1 << insn.vew;
    emask = (w == 8) ? '1 : ((64'd1 << (8 * w)) - 1);
    res   = '0;
    for (int e = 0; e < 8 / w; e++) begin
      sh = 8 * w * e;
      a  = insn.use_scalar ? (insn.scalar_op & emask) : ((vs1 >> sh) & emask);
      b  = (vs2 >> sh) & emask;
      c  = (vd >> sh) & emask;
      case (insn.op)
        VMUL:    r = a * b;
        VMACC:   r = a * b + c;
        default: r = (insn.vm || mask[e * w]) ? a : b;
      endcase
      res = res | ((r & emask) << sh);
    end
    return res;
  endfunction

  // Active elements, minus masked-off ones for masked arithmetic
  function automatic strb_t active_bytes(mfpu_insn_t insn, int cnt, strb_t mask);
    int    w;
    strb_t be;
    w  = 1 << insn.vew;
    be = '0;
    for (int e = 0; e < 8 / w; e++) begin
      if (e < cnt && (insn.vm || insn.op == VMERGE || mask[e * w])) begin
        be = be | (strb_t'((1 << w) - 1) << (e * w));
      end
    end
    return be;
  endfunction

  task automatic send_insn(input mfpu_op_e op, input vew_e vew, input int vl, input int vd,
                           input bit vm, input bit use_scalar);
    mfpu_insn_t   insn;
    src_t         src;
    mfpu_result_t exp;
    int           epw;
    int           nwords;
    int           cnt;
    insn            = '0;
    insn.id         = next_id;
    insn.op         = op;
    insn.vew        = vew;
    insn.vl         = vlen_t'(vl);
    insn.vd         = 5'(vd);
    insn.vm         = vm;
    insn.use_scalar = use_scalar;
    insn.scalar_op  = {$random(seed), $random(seed)};
    insn.use_vs1    = !use_scalar;
    insn.use_vs2    = 1'b1;
    insn.use_vd     = (op == VMACC);
    next_id++;
    insn_i       = insn;
    insn_valid_i = 1'b1;
    do @(posedge clk_i); while (!insn_ready_o);
    // Accepted on this edge; queue its operand beats and expected words
    epw    = 8 >> vew;
    nwords = (vl + epw - 1) / epw;
    for (int k = 0; k < nwords; k++) begin
      src.used      = {op == VMACC, 1'b1, !use_scalar};
      src.need_mask = !vm;
      src.mask      = strb_t'($random(seed));
      src.ops[0]    = {$random(seed), $random(seed)};
      src.ops[1]    = {$random(seed), $random(seed)};
      src.ops[2]    = {$random(seed), $random(seed)};
      cnt           = (vl - k * epw < epw) ? vl - k * epw : epw;
      exp.id        = insn.id;
      exp.addr      = vaddr_t'(vd * VRegWords + k);
      exp.wdata     = model_word(insn, src.ops[0], src.ops[1], src.ops[2], src.mask);
      exp.be        = active_bytes(insn, cnt, src.mask);
      src_q.push_back(src);
      exp_q.push_back(exp);
      last_q.push_back(k == nwords - 1);
    end
    #10;
    insn_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name, input bit stall);
    cur_test  = name;
    stall_en  = stall;
    saw_full  = 1'b0;
    err_start = errors;
  endtask

  task automatic finish_test(input bit need_full);
    while (exp_q.size() != 0 || held != 0) @(negedge clk_i);
    if (need_full) begin
      assert (saw_full) else begin
        $display("%s: insn_ready_o never went low with four instructions held", cur_test);
        errors++;
      end
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("Test %s: %s", cur_test, (errors == err_start) ? "passed" : "failed");
  endtask

  // Operand and mask sources, one beat per word in instruction order
  always @(posedge clk_i) begin
    if (rst_ni && (operand_ready_o != '0 || mask_ready_o)) begin
      if (src_q.size() == 0) begin
        $display("%s: operand ready pulsed with no operand word queued", cur_test);
        errors++;
      end else begin
        assert (operand_ready_o == src_q[0].used && mask_ready_o == src_q[0].need_mask)
        else begin
          $display("Error: %s readies expected %b mask %b, actual %b mask %b", cur_test,
                   src_q[0].used, src_q[0].need_mask, operand_ready_o, mask_ready_o);
          errors++;
        end
        src_q.delete(0);
      end
    end
    #10;
    operand_valid_i = {3{src_q.size() != 0}};
    mask_valid_i    = (src_q.size() != 0);
    if (src_q.size() != 0) begin
      operand_i = src_q[0].ops;
      mask_i    = src_q[0].mask;
    end
  end

  always @(posedge clk_i) begin
    #10;
    result_gnt_i = stall_en ? (($random(seed) & 3) == 0) : 1'b1;
  end

  // Scoreboard for results, completion pulses and the queue-full flag
  always @(posedge clk_i) begin : scoreboard
    logic [NrVInsn-1:0] exp_done;
    mfpu_result_t       exp;
    elen_t              bm;
    if (rst_ni) begin
      exp_done = '0;
      assert (insn_ready_o == (held != 4)) else begin
        $display("Error: %s insn_ready_o expected %b, actual %b", cur_test, held != 4,
                 insn_ready_o);
        errors++;
      end
      if (!insn_ready_o) saw_full = 1'b1;
      if (result_req_o && result_gnt_i) begin
        if (exp_q.size() == 0) begin
          $display("%s: result granted with no result expected", cur_test);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          if (last_q.pop_front()) exp_done[exp.id] = 1'b1;
          for (int i = 0; i < StrbWidth; i++) begin
            bm[8*i +: 8] = {8{exp.be[i]}};
          end
          assert (exp.id == result_o.id && exp.addr == result_o.addr &&
                  exp.be == result_o.be && (exp.wdata & bm) == (result_o.wdata & bm))
          else begin
            $write("Error: %s expected id %0d addr %0d data %h be %b", cur_test,
                   exp.id, exp.addr, exp.wdata & bm, exp.be);
            $display(", actual id %0d addr %0d data %h be %b",
                     result_o.id, result_o.addr, result_o.wdata & bm, result_o.be);
            errors++;
          end
        end
      end
      assert (done_o == exp_done) else begin
        $display("Error: %s done_o expected %b, actual %b", cur_test, exp_done, done_o);
        errors++;
      end
      if (insn_valid_i && insn_ready_o) held++;
      if (done_o != '0) held--;
    end
  end

  initial begin
    #(NumTests * 2000 * ClkPeriod);
    $display("%s: watchdog expired after %0d cycles without finishing", cur_test,
             NumTests * 2000);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;

    start_test("vmul_widths", 1'b0);
    for (int w = 0; w < 4; w++) begin
      send_insn(VMUL, vew_e'(w), 2 * (8 >> w), w + 1, 1'b1, 1'b0);
    end
    finish_test(1'b0);

    start_test("vmacc_scalar", 1'b0);
    send_insn(VMACC, EW16, 8, 6, 1'b1, 1'b1);
    send_insn(VMACC, EW32, 6, 7, 1'b1, 1'b1);
    finish_test(1'b0);

    start_test("mask_merge", 1'b0);
    send_insn(VMUL, EW8, 16, 8, 1'b0, 1'b0);
    send_insn(VMERGE, EW16, 8, 9, 1'b0, 1'b1);
    send_insn(VMERGE, EW64, 4, 10, 1'b0, 1'b1);
    finish_test(1'b0);

    start_test("partial_tail", 1'b0);
    send_insn(VMUL, EW16, 11, 5, 1'b1, 1'b0);
    send_insn(VMACC, EW8, 13, 12, 1'b1, 1'b0);
    finish_test(1'b0);

    // Slow grants back up the result queue until the instruction queue fills
    start_test("stalled_queue", 1'b1);
    send_insn(VMUL, EW8, 64, 16, 1'b1, 1'b0);
    send_insn(VMACC, EW32, 10, 17, 1'b1, 1'b1);
    send_insn(VMERGE, EW16, 20, 18, 1'b0, 1'b1);
    send_insn(VMUL, EW64, 5, 19, 1'b0, 1'b0);
    send_insn(VMACC, EW8, 30, 20, 1'b1, 1'b0);
    finish_test(1'b1);

    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/mfpu_pkg.sv
verilog/mfpu_result_queue.sv
verilog/mfpu_insn_queue.sv
verilog/mfpu_issue.sv
verilog/mfpu_simd_mul.sv
verilog/mfpu_writeback.sv
verilog/vmfpu.sv
verif/vmfpu_properties.sv
verif/tb_vmfpu.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_vmfpu
FILELIST := compile.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
